// ==== msdft.f ====
common/msdft_pkg.sv
common/axil_pkg.sv
rtl/comb_delay.sv
twiddle_ram/twiddle_ram.sv
rtl/complex_mult.sv
rtl/integ_cast.sv
rtl/msdft_core.sv
tests/msdft_tb.sv

// ==== Bender.yml ====
package:
  name: msdft

sources:
  - common/msdft_pkg.sv
  - common/axil_pkg.sv
  - rtl/comb_delay.sv
  - twiddle_ram/twiddle_ram.sv
  - rtl/complex_mult.sv
  - rtl/integ_cast.sv
  - rtl/msdft_core.sv
  - target: test
    files:
      - tests/msdft_tb.sv

// ==== tests/msdft_tb.sv ====
module msdft_tb import msdft_pkg::*, axil_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int dft_len = 128;
    localparam int aw = $clog2(dft_len);
    localparam int tmo = 200;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    din_cplx_t     din = '0;
    logic          din_valid = 1'b0;
    logic [aw-1:0] frame_len_m1 = aw'(dft_len - 1);
    dout_cplx_t    dout;
    logic          dout_valid;
    axil_req_t     bus = '0;
    axil_rsp_t     bus_rsp;

    // reference model state
    logic [31:0]        twidd_model [dft_len];
    din_cplx_t          hist_q [$];
    logic [63:0]        exp_q [$];
    logic [5:0]         valid_pipe = '0;
    int                 tw_idx = 0;
    logic signed [33:0] acc_re = '0;
    logic signed [33:0] acc_im = '0;
    logic [31:0]        lfsr = 32'd96944;
    int                 value_errs = 0;
    int                 other_errs = 0;

    msdft_core #(.DFT_LEN(dft_len)) u_msdft_core (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid    (din_valid),
        .frame_len_m1 (frame_len_m1),
        .dout         (dout),
        .dout_valid   (dout_valid),
        .bus          (bus),
        .bus_rsp      (bus_rsp)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA3000000 : 32'h0);
        end
        return r;
    endfunction

    // drop 5 fraction bits with round half up, clamp to 32 bits
    function automatic logic [31:0] scale_output(input logic signed [33:0] x);
        longint r;
        r = (longint'(x) + 16) >>> 5;
        if (r > 64'sd2147483647) begin
            r = 64'sd2147483647;
        end else if (r < -64'sd2147483648) begin
            r = -64'sd2147483648;
        end
        return r[31:0];
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // 0 awready, 1 arready, 2 bvalid, 3 rvalid, else model drained
    function automatic logic flag(input int sel);
        case (sel)
            0: return bus_rsp.awready;
            1: return bus_rsp.arready;
            2: return bus_rsp.bvalid;
            3: return bus_rsp.rvalid;
            default: return exp_q.size() == 0 && valid_pipe == 0;
        endcase
    endfunction

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!flag(sel) && n <= tmo);
        if (!flag(sel)) begin
            other_errs++;
            $display("timeout waiting for %s", what);
            $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
            $display("FAIL: see errors above");
            $finish;
        end
    endtask

    task automatic apply_reset(input int len_m1);
        @(posedge clk);
        rst <= 1'b1;
        din_valid <= 1'b0;
        frame_len_m1 <= aw'(len_m1);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // idle straight out of reset
        @(negedge clk);
        compare("dout_valid", 64'(dout_valid), 64'd0);
        compare("bvalid", 64'(bus_rsp.bvalid), 64'd0);
        compare("rvalid", 64'(bus_rsp.rvalid), 64'd0);
        compare("awready", 64'(bus_rsp.awready), 64'd1);
        compare("wready", 64'(bus_rsp.wready), 64'd1);
        compare("arready", 64'(bus_rsp.arready), 64'd1);
    endtask

    task automatic bus_xfer(input logic wr, input int idx, input logic [31:0] data,
                            input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (wr && strb[b]) begin
                twidd_model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        @(posedge clk);
        bus.awaddr <= axil_addr_width'(idx * 4);
        bus.araddr <= axil_addr_width'(idx * 4);
        bus.wdata <= data;
        bus.wstrb <= strb;
        bus.awvalid <= wr;
        bus.wvalid <= wr;
        bus.arvalid <= !wr;
        wait_for(wr ? 0 : 1, "address ready");
        if (wr) begin
            compare("wready", 64'(bus_rsp.wready), 64'd1);
        end
        @(posedge clk);
        bus.awvalid <= 1'b0;
        bus.wvalid <= 1'b0;
        bus.arvalid <= 1'b0;
        wait_for(wr ? 2 : 3, "response valid");
        // manager stalls the response a few cycles
        repeat (rand_bits(2)) begin
            @(negedge clk);
            compare(wr ? "bvalid" : "rvalid", 64'(flag(wr ? 2 : 3)), 64'd1);
        end
        @(posedge clk);
        bus.bready <= wr;
        bus.rready <= !wr;
        @(negedge clk);
        compare("bresp", 64'(bus_rsp.bresp), 64'(resp_okay));
        compare("rresp", 64'(bus_rsp.rresp), 64'(resp_okay));
        if (!wr) begin
            compare("rdata", 64'(bus_rsp.rdata), 64'(twidd_model[idx]));
        end
        @(posedge clk);
        bus.bready <= 1'b0;
        bus.rready <= 1'b0;
    endtask

    task automatic send_stream(input int count, input logic full_scale);
        for (int i = 0; i < count; i++) begin
            // idle gap of one to four cycles now and then
            if (rand_bits(2) == 0) begin
                @(posedge clk);
                din_valid <= 1'b0;
                repeat (rand_bits(2)) @(posedge clk);
            end
            @(posedge clk);
            din_valid <= 1'b1;
            din.re <= full_scale ? 8'h80 : 8'(rand_bits(8));
            din.im <= full_scale ? 8'h80 : 8'(rand_bits(8));
        end
        @(posedge clk);
        din_valid <= 1'b0;
        wait_for(4, "the pending outputs to drain");
    endtask

    // model runs on the falling edge, away from the driving edge
    always @(negedge clk) begin : model
        din_cplx_t   old;
        logic [31:0] tw;
        int          c_re;
        int          c_im;
        longint      p_re;
        longint      p_im;
        if (rst) begin
            hist_q.delete();
            exp_q.delete();
            valid_pipe = '0;
            tw_idx = 0;
            acc_re = '0;
            acc_im = '0;
        end else begin
            compare("dout_valid", 64'(dout_valid), 64'(valid_pipe[5]));
            if (dout_valid && valid_pipe[5]) begin
                compare("dout", 64'(dout), exp_q.pop_front());
            end
            valid_pipe = {valid_pipe[4:0], din_valid};
            if (din_valid) begin
                // zero until a full frame of history exists
                old = '0;
                if (hist_q.size() > frame_len_m1) begin
                    old = hist_q[hist_q.size() - frame_len_m1 - 1];
                end
                c_re = din.re - old.re;
                c_im = din.im - old.im;
                tw = twidd_model[tw_idx];
                p_re = c_re * $signed(tw[31:16]) - c_im * $signed(tw[15:0]);
                p_im = c_re * $signed(tw[15:0]) + c_im * $signed(tw[31:16]);
                acc_re = acc_re + p_re[33:0];
                acc_im = acc_im + p_im[33:0];
                exp_q.push_back({scale_output(acc_re), scale_output(acc_im)});
                tw_idx = (tw_idx == frame_len_m1) ? 0 : tw_idx + 1;
                hist_q.push_back(din);
                if (hist_q.size() > max_dft_len) begin
                    void'(hist_q.pop_front());
                end
            end
        end
    end

    initial begin : main
        int          idx;
        logic [31:0] word;
        logic [3:0]  strb;
        apply_reset(dft_len - 1);
        // full words first, then random strobes on top
        for (int i = 0; i < dft_len; i++) begin
            word = rand_bits(32);
            bus_xfer(1'b1, i, word, 4'hf);
        end
        repeat (64) begin
            idx = rand_bits(aw);
            word = rand_bits(32);
            strb = 4'(rand_bits(4));
            bus_xfer(1'b1, idx, word, strb);
        end
        for (int i = 0; i < dft_len; i++) begin
            bus_xfer(1'b0, i, '0, '0);
        end
        send_stream(400, 1'b0);
        apply_reset(15);
        send_stream(120, 1'b0);
        // full-scale twiddles against a constant negative input
        apply_reset(dft_len - 1);
        for (int i = 0; i < dft_len; i++) begin
            bus_xfer(1'b1, i, 32'h7fff8000, 4'hf);
        end
        send_stream(300, 1'b1);
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== rtl/msdft_core.sv ====
module msdft_core import msdft_pkg::*, axil_pkg::*; #(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  din_cplx_t                  din,
    input  logic                       din_valid,
    input  logic [$clog2(DFT_LEN)-1:0] frame_len_m1,
    output dout_cplx_t                 dout,
    output logic                       dout_valid,
    input  axil_req_t                  bus,
    output axil_rsp_t                  bus_rsp
);

    localparam int aw = $clog2(DFT_LEN);

    if (DFT_LEN > max_dft_len || (DFT_LEN & (DFT_LEN - 1)) != 0) begin : g_len_check
        $error("DFT_LEN must be a power of two no larger than max_dft_len");
    end

    comb_cplx_t    comb;
    logic          comb_valid;
    comb_cplx_t    comb_q;
    logic          twidd_valid;
    logic [aw-1:0] twidd_addr;
    twidd_cplx_t   twidd;
    mult_cplx_t    mult;
    logic          mult_valid;

    comb_delay #(.DFT_LEN(DFT_LEN)) u_comb_delay (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid    (din_valid),
        .frame_len_m1 (frame_len_m1),
        .dout         (comb),
        .dout_valid   (comb_valid)
    );

    // twiddle index steps with each comb output, ram answers one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            twidd_addr <= '0;
            twidd_valid <= 1'b0;
        end else begin
            twidd_valid <= comb_valid;
            if (comb_valid) begin
                twidd_addr <= (twidd_addr == frame_len_m1) ? '0 : twidd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (comb_valid) begin
            comb_q <= comb;
        end
    end

    twiddle_ram #(.DFT_LEN(DFT_LEN)) u_twiddle_ram (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .bus_rsp (bus_rsp),
        .rd_addr (twidd_addr),
        .rd_data (twidd)
    );

    complex_mult u_complex_mult (
        .clk       (clk),
        .rst       (rst),
        .a         (comb_q),
        .b         (twidd),
        .in_valid  (twidd_valid),
        .p         (mult),
        .out_valid (mult_valid)
    );

    integ_cast u_integ_cast (
        .clk        (clk),
        .rst        (rst),
        .din        (mult),
        .din_valid  (mult_valid),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

// ==== rtl/integ_cast.sv ====
module integ_cast import msdft_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mult_cplx_t din,
    input  logic       din_valid,
    output dout_cplx_t dout,
    output logic       dout_valid
);

    localparam int shift = mult_point - dout_point;
    localparam int work_width = integ_width + 1;
    localparam int half = 1 << (shift - 1);

    localparam logic signed [dout_width-1:0] out_max = {1'b0, {(dout_width-1){1'b1}}};
    localparam logic signed [dout_width-1:0] out_min = {1'b1, {(dout_width-1){1'b0}}};

    integ_cplx_t integ;
    logic        integ_valid;

    // round half up, then clamp to the output range
    function automatic logic signed [dout_width-1:0] round_sat(
        input logic signed [integ_width-1:0] x
    );
        logic signed [work_width-1:0] r;
        r = (work_width'(x) + half) >>> shift;
        if (r > out_max) begin
            return out_max;
        end else if (r < out_min) begin
            return out_min;
        end
        return dout_width'(r);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            integ <= '0;
            integ_valid <= 1'b0;
        end else begin
            integ_valid <= din_valid;
            if (din_valid) begin
                integ.re <= integ.re + din.re;
                integ.im <= integ.im + din.im;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (integ_valid) begin
            dout.re <= round_sat(integ.re);
            dout.im <= round_sat(integ.im);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= integ_valid;
        end
    end

endmodule

// ==== rtl/complex_mult.sv ====
module complex_mult import msdft_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  comb_cplx_t  a,
    input  twidd_cplx_t b,
    input  logic        in_valid,
    output mult_cplx_t  p,
    output logic        out_valid
);

    localparam int prod_width = comb_width + twidd_width;

    logic signed [prod_width-1:0] rr;
    logic signed [prod_width-1:0] ii;
    logic signed [prod_width-1:0] ri;
    logic signed [prod_width-1:0] ir;
    logic                         prod_valid;

    // stage one, partial products
    always_ff @(posedge clk) begin
        if (in_valid) begin
            rr <= a.re * b.re;
            ii <= a.im * b.im;
            ri <= a.re * b.im;
            ir <= a.im * b.re;
        end
    end

    // stage two, combine
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            p.re <= rr - ii;
            p.im <= ri + ir;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            out_valid <= prod_valid;
        end
    end

endmodule

// ==== twiddle_ram/twiddle_ram.sv ====
module twiddle_ram import msdft_pkg::*, axil_pkg::*; #(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  axil_req_t                  bus,
    output axil_rsp_t                  bus_rsp,
    input  logic [$clog2(DFT_LEN)-1:0] rd_addr,
    output twidd_cplx_t                rd_data
);

    localparam int aw = $clog2(DFT_LEN);

    logic [axil_data_width-1:0] mem [DFT_LEN];
    logic [aw-1:0]              wr_idx;
    logic [aw-1:0]              ar_idx;
    logic                       wr_accept;
    logic                       rd_accept;
    logic                       bvalid;
    logic                       rvalid;
    logic [axil_data_width-1:0] rdata;

    // word index from the byte address
    assign wr_idx = bus.awaddr[aw+1:2];
    assign ar_idx = bus.araddr[aw+1:2];

    // address and data taken together, one response outstanding
    assign wr_accept = bus.awvalid && bus.wvalid && !bvalid;
    assign rd_accept = bus.arvalid && !rvalid;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int i = 0; i < axil_strb_width; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    // datapath port, never stalls
    always_ff @(posedge clk) begin
        rd_data <= twidd_cplx_t'(mem[rd_addr]);
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= mem[ar_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bus.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (bus.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        bus_rsp.awready = !bvalid;
        bus_rsp.wready = !bvalid;
        bus_rsp.bresp = resp_okay;
        bus_rsp.bvalid = bvalid;
        bus_rsp.arready = !rvalid;
        bus_rsp.rdata = rdata;
        bus_rsp.rresp = resp_okay;
        bus_rsp.rvalid = rvalid;
    end

    bvalid_hold: assert property (
        @(posedge clk) disable iff (rst) bvalid && !bus.bready |=> bvalid
    );

endmodule

// ==== rtl/comb_delay.sv ====
module comb_delay import msdft_pkg::*; #(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  din_cplx_t                  din,
    input  logic                       din_valid,
    input  logic [$clog2(DFT_LEN)-1:0] frame_len_m1,
    output comb_cplx_t                 dout,
    output logic                       dout_valid
);

    localparam int aw = $clog2(DFT_LEN);

    din_cplx_t     mem [DFT_LEN];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   fill_cnt;
    logic          hist_ok;
    din_cplx_t     old_smp;

    // sample written frame_len_m1+1 valids ago
    assign rd_ptr = wr_ptr - frame_len_m1 - 1'b1;

    // history not yet written reads as zero
    assign hist_ok = fill_cnt > {1'b0, frame_len_m1};
    assign old_smp = hist_ok ? mem[rd_ptr] : '0;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            fill_cnt <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
            if (din_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (!hist_ok) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout.re <= din.re - old_smp.re;
            dout.im <= din.im - old_smp.im;
        end
    end

    // frame length may only change across a reset
    frame_len_stable: assert property (
        @(posedge clk) disable iff (rst) din_valid |-> $stable(frame_len_m1)
    );

endmodule

// ==== common/axil_pkg.sv ====
package axil_pkg;

    // byte address, data and strobe widths
    localparam int axil_addr_width = 10;
    localparam int axil_data_width = 32;
    localparam int axil_strb_width = axil_data_width / 8;

    localparam logic [1:0] resp_okay = 2'b00;

    // manager to subordinate
    typedef struct packed {
        logic [axil_addr_width-1:0] awaddr;
        logic                       awvalid;
        logic [axil_data_width-1:0] wdata;
        logic [axil_strb_width-1:0] wstrb;
        logic                       wvalid;
        logic                       bready;
        logic [axil_addr_width-1:0] araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic [1:0]                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [axil_data_width-1:0] rdata;
        logic [1:0]                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

endpackage

// ==== common/msdft_pkg.sv ====
package msdft_pkg;

    // input samples
    localparam int din_width = 8;
    localparam int din_point = 7;

    // comb difference needs one extra bit
    localparam int comb_width = din_width + 1;

    // twiddle factors
    localparam int twidd_width = 16;
    localparam int twidd_point = 14;

    // full complex product, one guard bit for the add
    localparam int mult_width = comb_width + twidd_width + 1;
    localparam int mult_point = din_point + twidd_point;

    localparam int max_dft_len = 256;

    // integrator grows by log2 of the longest frame
    localparam int integ_width = mult_width + $clog2(max_dft_len);

    localparam int dout_width = 32;
    localparam int dout_point = 16;

    typedef struct packed {
        logic signed [din_width-1:0] re;
        logic signed [din_width-1:0] im;
    } din_cplx_t;

    typedef struct packed {
        logic signed [comb_width-1:0] re;
        logic signed [comb_width-1:0] im;
    } comb_cplx_t;

    // re sits in the upper half of the bus word
    typedef struct packed {
        logic signed [twidd_width-1:0] re;
        logic signed [twidd_width-1:0] im;
    } twidd_cplx_t;

    typedef struct packed {
        logic signed [mult_width-1:0] re;
        logic signed [mult_width-1:0] im;
    } mult_cplx_t;

    typedef struct packed {
        logic signed [integ_width-1:0] re;
        logic signed [integ_width-1:0] im;
    } integ_cplx_t;

    typedef struct packed {
        logic signed [dout_width-1:0] re;
        logic signed [dout_width-1:0] im;
    } dout_cplx_t;

endpackage
